// File: Bender.yml
package:
  name: uart_echo

sources:
  # rtl, packages first
  - files:
      - design/uart_pkg.sv
      - design/echo_pkg.sv
      - design/baud_timer.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/byte_fifo.sv
      - design/echo_ctrl.sv
      - design/uart_echo_top.sv

  # testbench
  - target: test
    files:
      - dv/uart_echo_asserts.sv
      - dv/uart_echo_tb.sv

// File: design/baud_timer.sv
`timescale 1ns/1ps

module baud_timer (
	input  logic CLK,
	input  logic rst,
	input  logic restart,
	input  logic half,
	output logic tick
);

	localparam uart_pkg::baud_cnt_t FULL_LOAD = uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1);
	localparam uart_pkg::baud_cnt_t HALF_LOAD = uart_pkg::baud_cnt_t'(uart_pkg::HALF_BIT - 1);

	uart_pkg::baud_cnt_t cnt;
	logic running; // no ticks before the first restart

	always_ff @(posedge CLK) begin
		if (rst) begin
			cnt <= '0;
			running <= 1'b0;
		end else if (restart) begin
			running <= 1'b1;
			cnt <= half ? HALF_LOAD : FULL_LOAD;
		end else if (running) begin
			if (cnt == '0)
				cnt <= FULL_LOAD; // free-runs on full bits after expiry
			else
				cnt <= cnt - 1'b1;
		end
	end

	// restart in cycle t gives tick in cycle t+N
	assign tick = running && (cnt == '0);

endmodule

// File: design/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 push,
	input  uart_pkg::data_byte_t push_data,
	input  logic                 pop,
	output uart_pkg::data_byte_t head,
	output logic                 empty,
	output logic                 full,
	output logic                 overrun
);

	uart_pkg::data_byte_t mem [echo_pkg::FIFO_DEPTH];

	echo_pkg::fifo_ptr_t wr_ptr;
	echo_pkg::fifo_ptr_t rd_ptr;
	echo_pkg::fifo_cnt_t count;

	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full  = (count == echo_pkg::fifo_cnt_t'(echo_pkg::FIFO_DEPTH));

	// a pop in the same cycle makes room even when full
	assign do_push = push && (!full || pop);
	assign do_pop  = pop && !empty;

	assign head = mem[rd_ptr]; // show-ahead

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overrun <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && !do_push)
				overrun <= 1'b1; // sticky until reset
		end
	end

endmodule

// File: design/echo_ctrl.sv
`timescale 1ns/1ps

module echo_ctrl (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 empty,
	input  uart_pkg::data_byte_t head,
	input  logic                 rx_valid,
	input  uart_pkg::data_byte_t rx_byte,
	input  logic                 tx_busy,
	output logic                 pop,
	output logic                 tx_start,
	output uart_pkg::data_byte_t tx_byte,
	output uart_pkg::data_byte_t led_n
);

	echo_pkg::echo_state_t state;

	// head is taken in the same cycle as the pop
	assign pop = (state == echo_pkg::echo_idle) && !empty;

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= echo_pkg::echo_idle;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				echo_pkg::echo_idle: begin
					if (!empty) begin
						tx_start <= 1'b1;
						state <= echo_pkg::echo_send;
					end
				end
				echo_pkg::echo_send: begin
					// tx_busy rises the cycle after tx_start
					state <= echo_pkg::echo_wait_done;
				end
				echo_pkg::echo_wait_done: begin
					if (!tx_busy)
						state <= echo_pkg::echo_idle;
				end
				default: state <= echo_pkg::echo_idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (pop)
			tx_byte <= head;
	end

	// leds are active low, show last good byte
	always_ff @(posedge CLK) begin
		if (rst)
			led_n <= '1;
		else if (rx_valid)
			led_n <= ~rx_byte;
	end

endmodule

// File: design/echo_pkg.sv
package echo_pkg;

	// kept tiny so overruns are easy to provoke
	localparam int FIFO_DEPTH = 4;

	typedef logic [1:0] fifo_ptr_t; // wraps at FIFO_DEPTH
	typedef logic [2:0] fifo_cnt_t; // 0 .. FIFO_DEPTH

	typedef enum logic [1:0] {
		echo_idle,
		echo_send,
		echo_wait_done
	} echo_state_t;

endpackage

// File: design/uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 rx,
	output logic                 tx,
	output uart_pkg::data_byte_t led_n,
	output logic                 fifo_full,
	output logic                 fifo_empty,
	output logic                 overrun,
	output logic                 frame_error
);

	uart_pkg::data_byte_t rx_byte;
	uart_pkg::data_byte_t head;
	uart_pkg::data_byte_t tx_byte;

	logic rx_valid;
	logic frame_err;
	logic pop;
	logic tx_start;
	logic tx_busy;

	uart_rx i_uart_rx (
		.CLK       (CLK),
		.rst       (rst),
		.rx        (rx),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.frame_err (frame_err)
	);

	byte_fifo i_byte_fifo (
		.CLK       (CLK),
		.rst       (rst),
		.push      (rx_valid),
		.push_data (rx_byte),
		.pop       (pop),
		.head      (head),
		.empty     (fifo_empty),
		.full      (fifo_full),
		.overrun   (overrun)
	);

	echo_ctrl i_echo_ctrl (
		.CLK      (CLK),
		.rst      (rst),
		.empty    (fifo_empty),
		.head     (head),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte),
		.tx_busy  (tx_busy),
		.pop      (pop),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.led_n    (led_n)
	);

	uart_tx i_uart_tx (
		.CLK      (CLK),
		.rst      (rst),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

	// sticky framing error, cleared only by reset
	always_ff @(posedge CLK) begin
		if (rst)
			frame_error <= 1'b0;
		else if (frame_err)
			frame_error <= 1'b1;
	end

endmodule

// File: design/uart_pkg.sv
package uart_pkg;

	// serial line timing, 10 clocks per bit on the 10 MHz clock
	localparam int CLKS_PER_BIT = 10;
	localparam int HALF_BIT     = 5; // start edge to mid-bit
	localparam int STOP_BITS    = 2; // sent by the transmitter

	typedef logic [7:0] data_byte_t;
	typedef logic [2:0] bit_idx_t;  // data bit position
	typedef logic [3:0] baud_cnt_t; // holds up to CLKS_PER_BIT-1

	typedef enum logic [1:0] {
		rx_st_idle,
		rx_st_start,
		rx_st_data,
		rx_st_stop
	} rx_state_t;

	typedef enum logic [1:0] {
		tx_st_idle,
		tx_st_start,
		tx_st_data,
		tx_st_stop
	} tx_state_t;

endpackage

// File: design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic                   rx,
	output uart_pkg::data_byte_t   rx_byte,
	output logic                   rx_valid,
	output logic                   frame_err
);

	uart_pkg::rx_state_t  state;
	uart_pkg::bit_idx_t   bit_idx;
	uart_pkg::data_byte_t shift_reg;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic fall;
	logic restart;
	logic tick;

	// two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge CLK) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall    = rx_prev && !rx_sync;
	assign restart = (state == uart_pkg::rx_st_idle) && fall;

	baud_timer i_baud_timer (
		.CLK     (CLK),
		.rst     (rst),
		.restart (restart),
		.half    (1'b1), // rx always starts on a half bit
		.tick    (tick)
	);

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= uart_pkg::rx_st_idle;
			bit_idx <= '0;
			rx_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				uart_pkg::rx_st_idle: begin
					if (fall)
						state <= uart_pkg::rx_st_start;
				end
				uart_pkg::rx_st_start: begin
					if (tick) begin
						bit_idx <= '0;
						// line back high at mid-bit means a glitch
						state <= rx_sync ? uart_pkg::rx_st_idle : uart_pkg::rx_st_data;
					end
				end
				uart_pkg::rx_st_data: begin
					if (tick) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= uart_pkg::rx_st_stop;
					end
				end
				uart_pkg::rx_st_stop: begin
					if (tick) begin
						rx_valid <= rx_sync;
						frame_err <= !rx_sync; // stop bit sampled low
						state <= uart_pkg::rx_st_idle;
					end
				end
				default: state <= uart_pkg::rx_st_idle;
			endcase
		end
	end

	// data shifts in lsb first
	always_ff @(posedge CLK) begin
		if (state == uart_pkg::rx_st_data && tick)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

	assign rx_byte = shift_reg;

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input  logic                 CLK,
	input  logic                 rst,
	input  uart_pkg::data_byte_t tx_byte,
	input  logic                 tx_start,
	output logic                 tx,
	output logic                 tx_busy
);

	localparam uart_pkg::bit_idx_t LAST_STOP = uart_pkg::bit_idx_t'(uart_pkg::STOP_BITS - 1);

	uart_pkg::tx_state_t  state;
	uart_pkg::bit_idx_t   bit_idx;
	uart_pkg::data_byte_t shift_reg;

	logic restart;
	logic tick;

	assign restart = (state == uart_pkg::tx_st_idle) && tx_start;

	baud_timer i_baud_timer (
		.CLK     (CLK),
		.rst     (rst),
		.restart (restart),
		.half    (1'b0),
		.tick    (tick)
	);

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= uart_pkg::tx_st_idle;
			bit_idx <= '0;
			tx <= 1'b1; // line idles high
			tx_busy <= 1'b0;
		end else begin
			case (state)
				uart_pkg::tx_st_idle: begin
					if (tx_start) begin
						tx <= 1'b0; // start bit
						tx_busy <= 1'b1;
						state <= uart_pkg::tx_st_start;
					end
				end
				uart_pkg::tx_st_start: begin
					if (tick) begin
						tx <= shift_reg[0];
						bit_idx <= '0;
						state <= uart_pkg::tx_st_data;
					end
				end
				uart_pkg::tx_st_data: begin
					if (tick) begin
						bit_idx <= bit_idx + 1'b1;
						tx <= (bit_idx == 3'd7) ? 1'b1 : shift_reg[0];
						if (bit_idx == 3'd7)
							state <= uart_pkg::tx_st_stop;
					end
				end
				uart_pkg::tx_st_stop: begin
					if (tick) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_STOP) begin
							tx_busy <= 1'b0;
							state <= uart_pkg::tx_st_idle;
						end
					end
				end
				default: state <= uart_pkg::tx_st_idle;
			endcase
		end
	end

	// byte latched on start, consumed lsb first
	always_ff @(posedge CLK) begin
		if (restart)
			shift_reg <= tx_byte;
		else if (tick && (state == uart_pkg::tx_st_start || state == uart_pkg::tx_st_data))
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

endmodule

// File: dv/uart_echo_asserts.sv
`timescale 1ns/1ps

module uart_echo_asserts (
	input logic                CLK,
	input logic                rst,
	input logic                tx,
	input logic                tx_busy,
	input logic                rx_valid,
	input logic                tx_start,
	input logic                fifo_full,
	input logic                fifo_empty,
	input logic                overrun
);

	int fail_cnt = 0; // read by the testbench summary

	// line sits at mark level between frames
	tx_idle_high: assert property (@(posedge CLK) disable iff (rst) !tx_busy |-> tx) else begin
		$error("tx low while the transmitter is idle");
		fail_cnt++;
	end

	rx_valid_pulse: assert property (@(posedge CLK) disable iff (rst)
			rx_valid |=> !rx_valid) else begin
		$error("rx_valid held for more than one cycle");
		fail_cnt++;
	end

	tx_start_pulse: assert property (@(posedge CLK) disable iff (rst)
			tx_start |=> !tx_start) else begin
		$error("tx_start held for more than one cycle");
		fail_cnt++;
	end

	flags_exclusive: assert property (@(posedge CLK) disable iff (rst)
			!(fifo_full && fifo_empty)) else begin
		$error("fifo full and empty at the same time");
		fail_cnt++;
	end

	overrun_sticky: assert property (@(posedge CLK) (!rst && overrun) |=> overrun) else begin
		$error("overrun cleared without reset");
		fail_cnt++;
	end

	start_when_idle: assert property (@(posedge CLK) disable iff (rst)
			tx_start |-> !tx_busy) else begin
		$error("tx_start while the transmitter is busy");
		fail_cnt++;
	end

endmodule

// File: dv/uart_echo_tb.sv
`timescale 1ns/1ps

module uart_echo_tb;

	localparam int NUM_FRAMES     = 55; // 1 + 12 + 40 + 2 frames driven
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * 120 + 2000;

	logic                 CLK;
	logic                 rst;
	logic                 rx;
	logic                 tx;
	uart_pkg::data_byte_t led_n;
	logic                 fifo_full;
	logic                 fifo_empty;
	logic                 overrun;
	logic                 frame_error;

	uart_pkg::data_byte_t exp_q[$]; // bytes that should come back
	uart_pkg::data_byte_t rcv_q[$]; // bytes decoded from tx
	uart_pkg::data_byte_t last_good;
	int err_cnt = 0;
	int cycle_cnt = 0;
	int full_cycles = 0; // cycles with the fifo full

	uart_echo_top i_uart_echo_top (
		.CLK         (CLK),
		.rst         (rst),
		.rx          (rx),
		.tx          (tx),
		.led_n       (led_n),
		.fifo_full   (fifo_full),
		.fifo_empty  (fifo_empty),
		.overrun     (overrun),
		.frame_error (frame_error)
	);

	bind uart_echo_top uart_echo_asserts i_uart_echo_asserts (
		.CLK        (CLK),
		.rst        (rst),
		.tx         (tx),
		.tx_busy    (tx_busy),
		.rx_valid   (rx_valid),
		.tx_start   (tx_start),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty),
		.overrun    (overrun)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	always @(posedge CLK) begin
		if (fifo_full)
			full_cycles <= full_cycles + 1;
	end

	task automatic check_value(input string test, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("[ERROR] %s: expected %0h, actual %0h", test, expected, actual);
			err_cnt++;
		end
	endtask

	// one serial bit, held for a full bit period
	task automatic drive_bit(input logic v);
		@(posedge CLK);
		rx <= v;
		repeat (uart_pkg::CLKS_PER_BIT - 1) @(posedge CLK);
	endtask

	task automatic send_frame(input uart_pkg::data_byte_t b, input logic bad_stop,
			input int gap_bits);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(b[i]); // lsb first
		drive_bit(!bad_stop);
		repeat (gap_bits) drive_bit(1'b1);
		if (!bad_stop)
			last_good = b;
	endtask

	task automatic check_led(input uart_pkg::data_byte_t b);
		uart_pkg::data_byte_t led_exp;
		led_exp = ~b;
		@(negedge CLK);
		check_value("led_value", led_exp, led_n);
	endtask

	// fifo empty and transmitter idle for a few cycles in a row
	task automatic wait_drained();
		int quiet;
		quiet = 0;
		while (quiet < 4) begin
			@(negedge CLK);
			if (fifo_empty && !i_uart_echo_top.tx_busy)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic compare_queues(input string test);
		check_value(test, exp_q.size(), rcv_q.size());
		for (int i = 0; i < exp_q.size() && i < rcv_q.size(); i++)
			check_value(test, exp_q[i], rcv_q[i]);
	endtask

	// greedy match of received bytes against the sent order
	function automatic int matched_in_order();
		int j;
		int hits;
		j = 0;
		hits = 0;
		foreach (rcv_q[i]) begin
			while (j < exp_q.size() && exp_q[j] != rcv_q[i])
				j++;
			if (j < exp_q.size()) begin
				hits++;
				j++;
			end
		end
		return hits;
	endfunction

	initial begin : tx_monitor
		uart_pkg::data_byte_t b;
		wait (rst === 1'b0);
		forever begin
			@(negedge tx);
			repeat (uart_pkg::HALF_BIT) @(negedge CLK); // middle of start bit
			check_value("tx_start_bit", 0, tx);
			for (int i = 0; i < 8; i++) begin
				repeat (uart_pkg::CLKS_PER_BIT) @(negedge CLK);
				b[i] = tx;
			end
			for (int s = 0; s < uart_pkg::STOP_BITS; s++) begin
				repeat (uart_pkg::CLKS_PER_BIT) @(negedge CLK);
				check_value("tx_stop_bit", 1, tx);
			end
			rcv_q.push_back(b);
		end
	end

	initial begin : main
		uart_pkg::data_byte_t b;
		int fails;
		int full_base;
		void'($urandom(32'h748f_f847));
		rst <= 1'b1;
		rx <= 1'b1;
		repeat (5) @(posedge CLK);
		rst <= 1'b0;

		b = uart_pkg::data_byte_t'($urandom);
		exp_q.push_back(b);
		send_frame(b, 1'b0, 2);
		check_led(b);
		wait_drained();
		compare_queues("single_echo");
		check_value("single_echo", 1, fifo_empty);

		exp_q.delete();
		rcv_q.delete();
		full_base = full_cycles;
		for (int n = 0; n < 12; n++) begin
			b = uart_pkg::data_byte_t'($urandom);
			exp_q.push_back(b);
			send_frame(b, 1'b0, 2 + $urandom_range(2)); // slower than the echo
			check_led(b);
		end
		wait_drained();
		compare_queues("ordered_burst");
		check_value("ordered_burst", 0, overrun);
		check_value("ordered_burst", full_base, full_cycles); // never full

		exp_q.delete();
		rcv_q.delete();
		full_base = full_cycles;
		for (int n = 0; n < 40; n++) begin
			b = uart_pkg::data_byte_t'($urandom);
			exp_q.push_back(b);
			send_frame(b, 1'b0, 0);
		end
		wait_drained();
		check_value("overrun_drop", 1, overrun);
		check_value("overrun_drop", 1, full_cycles > full_base);
		check_value("overrun_drop", rcv_q.size(), matched_in_order());
		check_value("overrun_drop", 1, rcv_q.size() < exp_q.size());

		exp_q.delete();
		rcv_q.delete();
		send_frame(uart_pkg::data_byte_t'($urandom), 1'b1, 2);
		check_led(last_good); // bad frame leaves the leds alone
		check_value("framing_error", 1, frame_error);
		b = uart_pkg::data_byte_t'($urandom);
		exp_q.push_back(b);
		send_frame(b, 1'b0, 2);
		check_led(b);
		wait_drained();
		compare_queues("framing_error");

		@(posedge CLK);
		rst <= 1'b1;
		repeat (5) @(posedge CLK);
		rst <= 1'b0;
		@(negedge CLK);
		check_value("reset_clear", 0, overrun);
		check_value("reset_clear", 0, frame_error);
		check_value("reset_clear", 1, fifo_empty);
		check_value("reset_clear", 0, fifo_full);
		check_value("reset_clear", 8'hff, led_n);
		check_value("reset_clear", 1, tx);

		fails = i_uart_echo_top.i_uart_echo_asserts.fail_cnt;
		$display("check errors: %0d, assertion failures: %0d", err_cnt, fails);
		if (err_cnt == 0 && fails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: vlog.f
design/uart_pkg.sv
design/echo_pkg.sv
design/baud_timer.sv
design/uart_rx.sv
design/uart_tx.sv
design/byte_fifo.sv
design/echo_ctrl.sv
design/uart_echo_top.sv
dv/uart_echo_asserts.sv
dv/uart_echo_tb.sv
